//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // widths
    localparam int xlen_default = 64;   // data path width at the top level
    localparam int ilen         = 32;   // instruction word

    typedef logic [4:0] reg_idx_t;      // x0..x31

    // kept major opcodes only
    typedef enum logic [6:0] {
        op_load   = 7'b0000011,
        op_imm    = 7'b0010011,
        op_store  = 7'b0100011,
        op_r      = 7'b0110011,
        op_branch = 7'b1100011
    } opcode_t;

    // class command from the control unit
    typedef enum logic [3:0] {
        cmd_r = 4'd0,
        cmd_i = 4'd1,
        cmd_s = 4'd2,
        cmd_b = 4'd3
    } alu_cmd_t;

    // alu op codes
    typedef enum logic [3:0] {
        alu_and = 4'b0000,
        alu_or  = 4'b0001,
        alu_add = 4'b0010,
        alu_sub = 4'b0110
    } alu_op_t;

    // one instruction per pass through the three phases
    typedef enum logic [1:0] {
        ph_fetch  = 2'd0,
        ph_exec   = 2'd1,
        ph_commit = 2'd2
    } phase_t;

    // control unit levels sampled in commit
    typedef struct packed {
        logic     rf_we;     // write back to register file
        logic     d_mem_we;  // store
        logic     pc_src;    // beq
        logic     rf_src;    // 1 = load data, 0 = alu
        logic     alu_src;   // 1 = offset as operand b
        alu_cmd_t alu_cmd;
    } ctrl_t;

    typedef struct packed {
        reg_idx_t   ra;
        reg_idx_t   rb;
        reg_idx_t   rw;
        logic [2:0] funct3;
        logic [6:0] funct7;
    } fields_t;

    // equal sits in bit 0
    typedef struct packed {
        logic spare;         // tied low
        logic overflow;
        logic msb;
        logic equal;
    } alu_flags_t;

endpackage

`default_nettype wire

//--- design/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import rv_pkg::*; #(
    parameter int XLEN     = 64,
    parameter int I_ADDR_W = 6
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [ilen-1:0]     i_mem_data,   // combinational from imem
    input  wire logic                branch_taken, // pc_src & equal, from execute
    input  wire logic [XLEN-1:0]     offset,
    output phase_t                   phase,
    output logic      [ilen-1:0]     instr,
    output logic      [I_ADDR_W-1:0] i_mem_addr
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_next;
    phase_t          phase_next;

    // fetch -> exec -> commit -> fetch
    always_comb begin
        unique case (phase)
            ph_fetch: phase_next = ph_exec;
            ph_exec:  phase_next = ph_commit;
            default:  phase_next = ph_fetch; // commit, and recovery from the unused code
        endcase
    end

    // taken beq jumps relative to the current pc
    assign pc_next = branch_taken ? (pc + offset) : (pc + XLEN'(4));

    assign i_mem_addr = pc[I_ADDR_W+1:2]; // word address

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= ph_fetch;
            pc    <= '0;
            instr <= '0;
        end else begin
            phase <= phase_next;
            if (phase == ph_fetch) begin
                instr <= i_mem_data; // ir holds the word until the next fetch
            end
            if (phase == ph_commit) begin
                pc <= pc_next;       // one pc step per instruction
            end
        end
    end

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire logic [ilen-1:0] instr,
    output opcode_t              opcode,  // to the control unit
    output fields_t              fields,
    output logic      [XLEN-1:0] offset   // sign-extended immediate
);

    // field positions
    //   r: funct7 | rb | ra | funct3 | rw        | opcode
    //   i: imm[11:0]    | ra | funct3 | rw        | opcode
    //   s: imm[11:5] | rb | ra | funct3 | imm[4:0] | opcode
    //   b: imm[12|10:5] | rb | ra | funct3 | imm[4:1|11] | opcode

    logic [11:0] imm_i;
    logic [11:0] imm_s;
    logic [12:0] imm_b;

    assign opcode = opcode_t'(instr[6:0]);

    // register fields sit in the same place in every kept format
    assign fields.ra     = instr[19:15];
    assign fields.rb     = instr[24:20];
    assign fields.rw     = instr[11:7];
    assign fields.funct3 = instr[14:12];
    assign fields.funct7 = instr[31:25];

    assign imm_i = instr[31:20];
    assign imm_s = {instr[31:25], instr[11:7]};
    assign imm_b = {instr[31], instr[7], instr[30:25], instr[11:8], 1'b0}; // halfword offset

    // sign comes from instr[31] in all three layouts
    always_comb begin
        unique case (opcode)
            op_load,
            op_imm: begin
                offset = {{(XLEN-12){instr[31]}}, imm_i};
            end
            op_store: begin
                offset = {{(XLEN-12){instr[31]}}, imm_s};
            end
            op_branch: begin
                offset = {{(XLEN-13){instr[31]}}, imm_b};
            end
            default: begin
                offset = '0; // r-type has no immediate
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire reg_idx_t        ra,
    input  wire reg_idx_t        rb,
    input  wire reg_idx_t        rw,
    input  wire logic            we,      // already qualified with commit
    input  wire logic [XLEN-1:0] wdata,
    output logic      [XLEN-1:0] rdata_a,
    output logic      [XLEN-1:0] rdata_b
);

    logic [XLEN-1:0] regs [32];

    // x0 cleared at reset and never written, so it always reads zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rw != '0)) begin
            regs[rw] <= wdata;
        end
    end

    // async read ports
    assign rdata_a = regs[ra];
    assign rdata_b = regs[rb];

endmodule

`default_nettype wire

//--- design/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import rv_pkg::*; #(
    parameter int XLEN = 64
) (
    input  wire ctrl_t           ctrl,
    input  wire fields_t         fields,
    input  wire logic [XLEN-1:0] rdata_a,
    input  wire logic [XLEN-1:0] rdata_b,
    input  wire logic [XLEN-1:0] offset,
    output logic      [XLEN-1:0] result,
    output alu_flags_t           flags,
    output logic                 branch_taken
);

    alu_op_t         alu_op;
    logic [XLEN-1:0] opb;
    logic            sa;    // sign of a
    logic            sb;    // sign of b
    logic            sr;    // sign of result

    // alu control, r-type looks at funct fields, everything else adds
    always_comb begin
        alu_op = alu_add;
        if (ctrl.alu_cmd == cmd_r) begin
            unique case (fields.funct3)
                3'b000: begin
                    // sub only with funct7 = 0100000
                    alu_op = (fields.funct7 == 7'b0100000) ? alu_sub : alu_add;
                end
                3'b111:  alu_op = alu_and;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_add;
            endcase
        end
    end

    assign opb = ctrl.alu_src ? offset : rdata_b; // immediate or rb

    always_comb begin
        unique case (alu_op)
            alu_sub: result = rdata_a - opb;
            alu_and: result = rdata_a & opb;
            alu_or:  result = rdata_a | opb;
            default: result = rdata_a + opb;
        endcase
    end

    assign sa = rdata_a[XLEN-1];
    assign sb = opb[XLEN-1];
    assign sr = result[XLEN-1];

    assign flags.spare = 1'b0;
    assign flags.equal = (rdata_a == opb);  // beq compare
    assign flags.msb   = sr;

    // signed overflow, logic ops never overflow
    always_comb begin
        unique case (alu_op)
            alu_add: flags.overflow = (sa == sb) && (sr != sa);
            alu_sub: flags.overflow = (sa != sb) && (sr != sa);
            default: flags.overflow = 1'b0;
        endcase
    end

    assign branch_taken = ctrl.pc_src & flags.equal;

endmodule

`default_nettype wire

//--- design/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

module memory_stage import rv_pkg::*; #(
    parameter int XLEN     = 64,
    parameter int D_ADDR_W = 6
) (
    input  wire phase_t              phase,
    input  wire ctrl_t               ctrl,
    input  wire logic [XLEN-1:0]     result,      // alu out, also the address
    input  wire logic [XLEN-1:0]     rdata_b,     // store data
    input  wire logic [XLEN-1:0]     d_mem_rdata,
    output logic      [D_ADDR_W-1:0] d_mem_addr,
    output logic      [XLEN-1:0]     d_mem_wdata,
    output logic                     d_mem_write,
    output logic                     rf_we,
    output logic      [XLEN-1:0]     rf_wdata
);

    logic commit;

    assign commit = (phase == ph_commit); // control only valid here

    assign d_mem_addr  = result[D_ADDR_W-1:0];
    assign d_mem_wdata = rdata_b;
    assign d_mem_write = commit & ctrl.d_mem_we; // single-cycle strobe
    assign rf_we       = commit & ctrl.rf_we;

    // load data or alu result back to rw
    assign rf_wdata = ctrl.rf_src ? d_mem_rdata : result;

endmodule

`default_nettype wire

//--- design/rv_datapath_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_datapath_top import rv_pkg::*; #(
    parameter int XLEN     = xlen_default,
    parameter int I_ADDR_W = 6,
    parameter int D_ADDR_W = 6
) (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire ctrl_t               ctrl,        // levels from the control unit
    input  wire logic [ilen-1:0]     i_mem_data,
    input  wire logic [XLEN-1:0]     d_mem_rdata,
    output opcode_t                  opcode,
    output logic      [I_ADDR_W-1:0] i_mem_addr,
    output logic      [D_ADDR_W-1:0] d_mem_addr,
    output logic      [XLEN-1:0]     d_mem_wdata,
    output logic                     d_mem_write,
    output alu_flags_t               alu_flags
);

    phase_t          phase;
    logic [ilen-1:0] instr;         // ir contents
    fields_t         fields;
    logic [XLEN-1:0] offset;
    logic [XLEN-1:0] rdata_a;
    logic [XLEN-1:0] rdata_b;
    logic [XLEN-1:0] result;
    logic            branch_taken;
    logic            rf_we;         // gated to commit
    logic [XLEN-1:0] rf_wdata;

    fetch_stage #(
        .XLEN     (XLEN),
        .I_ADDR_W (I_ADDR_W)
    ) fetch_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_mem_data   (i_mem_data),
        .branch_taken (branch_taken),
        .offset       (offset),
        .phase        (phase),
        .instr        (instr),
        .i_mem_addr   (i_mem_addr)
    );

    decode_stage #(
        .XLEN (XLEN)
    ) decode_stage_inst (
        .instr  (instr),
        .opcode (opcode),
        .fields (fields),
        .offset (offset)
    );

    register_file #(
        .XLEN (XLEN)
    ) register_file_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .ra      (fields.ra),
        .rb      (fields.rb),
        .rw      (fields.rw),
        .we      (rf_we),
        .wdata   (rf_wdata),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    execute_stage #(
        .XLEN (XLEN)
    ) execute_stage_inst (
        .ctrl         (ctrl),
        .fields       (fields),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .offset       (offset),
        .result       (result),
        .flags        (alu_flags),
        .branch_taken (branch_taken)
    );

    memory_stage #(
        .XLEN     (XLEN),
        .D_ADDR_W (D_ADDR_W)
    ) memory_stage_inst (
        .phase       (phase),
        .ctrl        (ctrl),
        .result      (result),
        .rdata_b     (rdata_b),
        .d_mem_rdata (d_mem_rdata),
        .d_mem_addr  (d_mem_addr),
        .d_mem_wdata (d_mem_wdata),
        .d_mem_write (d_mem_write),
        .rf_we       (rf_we),
        .rf_wdata    (rf_wdata)
    );

endmodule

`default_nettype wire

//--- testbench/tb_rv_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_datapath import rv_pkg::*;;

    localparam int total_instr = 217;                  // steps over all tests
    localparam int watchdog_ns = 2 * total_instr * 60; // 3 cycles of 20 ns per step, x2

    logic            clk;
    logic            rst_n;
    ctrl_t           ctrl;
    logic [31:0]     i_mem_data;
    logic [63:0]     d_mem_rdata;
    opcode_t         opcode;
    logic [5:0]      i_mem_addr;
    logic [5:0]      d_mem_addr;
    logic [63:0]     d_mem_wdata;
    logic            d_mem_write;
    alu_flags_t      alu_flags;

    logic [31:0]     imem [64];
    logic [63:0]     dmem [64];
    logic [63:0]     model_regs [32];  // expected register contents
    logic [31:0]     prog [$];
    logic [5:0]      exp_addr [$];
    logic [63:0]     exp_data [$];
    logic [5:0]      got_addr [$];
    logic [63:0]     got_data [$];
    logic [5:0]      addr_q [$];       // i_mem_addr seen in each commit
    alu_flags_t      flag_q [$];       // alu_flags seen in each commit
    logic [5:0]      reset_addr;
    logic            reset_write;
    int              errors;
    int              test_errors;
    int              tests_run;
    int              tests_failed;

    rv_datapath_top rv_datapath_top_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .i_mem_data  (i_mem_data),
        .d_mem_rdata (d_mem_rdata),
        .opcode      (opcode),
        .i_mem_addr  (i_mem_addr),
        .d_mem_addr  (d_mem_addr),
        .d_mem_wdata (d_mem_wdata),
        .d_mem_write (d_mem_write),
        .alu_flags   (alu_flags)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    assign i_mem_data  = imem[i_mem_addr];   // async reads
    assign d_mem_rdata = dmem[d_mem_addr];

    always @(posedge clk) begin
        if (d_mem_write) begin
            dmem[d_mem_addr] <= d_mem_wdata;
            got_addr.push_back(d_mem_addr);
            got_data.push_back(d_mem_wdata);
        end
    end

    // control unit model with fields rf_we d_mem_we pc_src rf_src alu_src alu_cmd
    function automatic ctrl_t ctrl_for(input opcode_t op);
        case (op)
            op_r:      return '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, cmd_r};
            op_imm:    return '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, cmd_i};
            op_load:   return '{1'b1, 1'b0, 1'b0, 1'b1, 1'b1, cmd_i};
            op_store:  return '{1'b0, 1'b1, 1'b0, 1'b0, 1'b1, cmd_s};
            op_branch: return '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, cmd_b};
            default:   return '0; // empty ir after reset
        endcase
    endfunction

    always @(posedge clk) begin
        ctrl <= ctrl_for(opcode);
    end

    function automatic logic [63:0] sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic begin_test();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        test_errors = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i] = {32'hc0de_0000 + 32'(i), 32'(i) * 32'h0101_0101}; // per-address pattern
        end
    endtask

    task automatic add_imm(input reg_idx_t rw, input reg_idx_t ra, input logic [11:0] imm);
        prog.push_back({imm, ra, 3'b000, rw, op_imm});
        if (rw != 0) begin
            model_regs[rw] = model_regs[ra] + sext12(imm);
        end
    endtask

    task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3,
                          input reg_idx_t rw, input reg_idx_t ra, input reg_idx_t rb);
        logic [63:0] r;
        case (f3)
            3'b111:  r = model_regs[ra] & model_regs[rb];
            3'b110:  r = model_regs[ra] | model_regs[rb];
            default: r = (f7 == 7'b0100000) ? model_regs[ra] - model_regs[rb]
                                            : model_regs[ra] + model_regs[rb];
        endcase
        prog.push_back({f7, rb, ra, f3, rw, op_r});
        if (rw != 0) begin
            model_regs[rw] = r;
        end
    endtask

    task automatic load_word(input reg_idx_t rw, input reg_idx_t ra, input logic [11:0] imm);
        logic [5:0] addr;
        addr = 6'(model_regs[ra] + sext12(imm)); // low 6 bits of the sum
        prog.push_back({imm, ra, 3'b011, rw, op_load});
        if (rw != 0) begin
            model_regs[rw] = dmem[addr];
        end
    endtask

    task automatic store_word(input reg_idx_t rb, input reg_idx_t ra, input logic [11:0] imm);
        exp_addr.push_back(6'(model_regs[ra] + sext12(imm)));
        exp_data.push_back(model_regs[rb]);
        prog.push_back({imm[11:5], rb, ra, 3'b011, imm[4:0], op_store});
    endtask

    task automatic branch_eq(input reg_idx_t ra, input reg_idx_t rb, input int off);
        logic [12:0] o;
        o = off[12:0];
        prog.push_back({o[12], o[10:5], rb, ra, 3'b000, o[4:1], o[11], op_branch});
    endtask

    // load imem, pulse reset, then sample every commit cycle
    task automatic run_program(input int steps);
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0; // zero word acts as a nop
        end
        got_addr.delete();
        got_data.delete();
        addr_q.delete();
        flag_q.delete();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        reset_addr  = i_mem_addr;
        reset_write = d_mem_write;
        for (int s = 0; s < steps; s++) begin
            repeat (2) @(posedge clk);   // fetch, exec
            @(negedge clk);              // middle of commit
            addr_q.push_back(i_mem_addr);
            flag_q.push_back(alu_flags);
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    task automatic check_stores();
        assert (got_addr.size() == exp_addr.size()) else begin
            $display("store count wrong at %0t: %0d data memory writes seen, %0d expected",
                     $time, got_addr.size(), exp_addr.size());
            errors++;
            test_errors++;
        end
        for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
            check_val("d_mem_addr", exp_addr[i], got_addr[i]);
            check_val("d_mem_wdata", exp_data[i], got_data[i]);
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d mismatches", name, test_errors);
        end
    endtask

    task automatic reset_and_sequence();
        begin_test();
        for (int k = 0; k < 5; k++) begin
            add_imm(5'd0, 5'd0, 12'(k + 1)); // x0 target has no effect
        end
        run_program(5);
        check_val("i_mem_addr", 0, reset_addr);
        check_val("d_mem_write", 0, reset_write);
        for (int k = 0; k < 5; k++) begin
            check_val("i_mem_addr", k, addr_q[k]);
        end
        check_val("i_mem_addr", 5, i_mem_addr);
        check_stores();                      // none expected
        finish_test("reset and sequencing");
    endtask

    task automatic imm_and_store();
        begin_test();
        add_imm(5'd1, 5'd0, 12'h123);        // positive
        add_imm(5'd2, 5'd0, 12'hfab);        // -0x55
        add_imm(5'd3, 5'd0, 12'd16);         // base
        store_word(5'd1, 5'd3, 12'd8);
        store_word(5'd2, 5'd3, 12'hff8);     // base - 8
        run_program(5);
        check_stores();
        finish_test("immediates and stores");
    endtask

    task automatic alu_operations(input int pass);
        logic [63:0] a;
        logic [63:0] b;
        logic [64:0] w;                      // exact signed result with one guard bit
        int          add_step;
        int          sub_step;
        begin_test();
        add_imm(5'd1, 5'd0, 12'($urandom));
        for (int k = 0; k < 52; k++) begin
            reg_op(7'd0, 3'b000, 5'd1, 5'd1, 5'd1); // doubling pushes the value to the top bits
        end
        reg_op(7'b0100000, 3'b000, 5'd2, 5'd0, 5'd1); // x2 = -x1
        add_imm(5'd2, 5'd2, 12'($urandom));
        a = model_regs[1];
        b = model_regs[2];
        add_step = prog.size();
        reg_op(7'd0, 3'b000, 5'd3, 5'd1, 5'd2);
        store_word(5'd3, 5'd0, 12'd0);
        sub_step = prog.size();
        reg_op(7'b0100000, 3'b000, 5'd4, 5'd1, 5'd2);
        store_word(5'd4, 5'd0, 12'd8);
        reg_op(7'd0, 3'b111, 5'd5, 5'd1, 5'd2);
        store_word(5'd5, 5'd0, 12'd16);
        reg_op(7'd0, 3'b110, 5'd6, 5'd1, 5'd2);
        store_word(5'd6, 5'd0, 12'd24);
        run_program(prog.size());
        check_stores();
        // result does not fit 64 bits when the guard bit differs from bit 63
        w = {a[63], a} + {b[63], b};
        check_val("alu_flags.overflow", w[64] != w[63], flag_q[add_step].overflow);
        check_val("alu_flags.msb", w[63], flag_q[add_step].msb);
        check_val("alu_flags.spare", 0, flag_q[add_step].spare);
        w = {a[63], a} - {b[63], b};
        check_val("alu_flags.overflow", w[64] != w[63], flag_q[sub_step].overflow);
        check_val("alu_flags.msb", w[63], flag_q[sub_step].msb);
        finish_test($sformatf("alu operations, pass %0d", pass));
    endtask

    task automatic load_and_writeback();
        begin_test();
        add_imm(5'd1, 5'd0, 12'd40);
        load_word(5'd2, 5'd1, 12'd8);        // preloaded word at 48
        add_imm(5'd3, 5'd0, 12'($urandom));
        reg_op(7'd0, 3'b000, 5'd4, 5'd2, 5'd3);
        store_word(5'd4, 5'd1, 12'hff0);     // 40 - 16
        run_program(5);
        check_stores();
        finish_test("load and write-back");
    endtask

    task automatic equal_branch();
        begin_test();
        add_imm(5'd1, 5'd0, 12'd5);
        add_imm(5'd2, 5'd0, 12'd5);
        add_imm(5'd3, 5'd0, 12'd7);
        branch_eq(5'd1, 5'd2, 12);           // word 3 with equal operands
        add_imm(5'd0, 5'd0, 12'd1);          // skipped
        add_imm(5'd0, 5'd0, 12'd2);
        branch_eq(5'd1, 5'd3, -8);           // word 6 not taken
        branch_eq(5'd2, 5'd1, -24);          // word 7 taken backwards
        run_program(8);                      // flow 0 1 2 3 6 7 1 2
        check_val("alu_flags.equal", 1, flag_q[3].equal);
        check_val("i_mem_addr", (3 * 4 + 12) / 4, addr_q[4]);
        check_val("alu_flags.equal", 0, flag_q[4].equal);
        check_val("i_mem_addr", (6 * 4 + 4) / 4, addr_q[5]);
        check_val("alu_flags.equal", 1, flag_q[5].equal);
        check_val("i_mem_addr", (7 * 4 - 24) / 4, addr_q[6]);
        finish_test("equal branch");
    endtask

    task automatic register_zero();
        begin_test();
        add_imm(5'd0, 5'd0, 12'h7ff);
        add_imm(5'd1, 5'd0, 12'd99);
        reg_op(7'd0, 3'b000, 5'd0, 5'd1, 5'd1);
        store_word(5'd0, 5'd0, 12'd0);       // x0 must still be zero
        store_word(5'd0, 5'd1, 12'd8);
        run_program(5);
        check_stores();
        finish_test("register zero");
    endtask

    initial begin
        #(watchdog_ns);
        $display("timeout: tests still running after %0d ns", watchdog_ns);
        $display("Verification failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        ctrl  = '0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = 32'h0;
            dmem[i] = '0;
        end
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        void'($urandom(32'hde6fbccf));       // seed once
        reset_and_sequence();
        imm_and_store();
        for (int n = 1; n <= 3; n++) begin
            alu_operations(n);
        end
        load_and_writeback();
        equal_branch();
        register_zero();
        $display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
design/rv_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/register_file.sv
design/execute_stage.sv
design/memory_stage.sv
design/rv_datapath_top.sv
testbench/tb_rv_datapath.sv

//--- Bender.yml
package:
  name: rv_datapath

sources:
  - files:
      - design/rv_pkg.sv
      - design/fetch_stage.sv
      - design/decode_stage.sv
      - design/register_file.sv
      - design/execute_stage.sv
      - design/memory_stage.sv
      - design/rv_datapath_top.sv
  - target: test
    files:
      - testbench/tb_rv_datapath.sv
